//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       ?= biu_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build and run, exit status follows the testbench result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb.f
+incdir+verilog
verilog/biu_pkg.sv
verilog/biu_ahb_master.sv
verilog/ahb_sram.sv
verilog/biu_top.sv
verif/tb_clk_gen.sv
verif/biu_assert.sv
verif/biu_tb.sv

//--- verif/biu_assert.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite and core bus protocol assertions
// bound into the AHB master
//////////////////////////////////////////////////////////////////////

`include "biu_config.svh"

module biu_assert
  import biu_pkg::*;
(
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic [`BIU_PLEN-1:0] haddr_i,
  input htrans_e              htrans_i,
  input logic                 hwrite_i,
  input hsize_e               hsize_i,
  input hburst_e              hburst_i,
  input logic                 hready_i,
  input hresp_e               hresp_i,
  input logic                 ack_i,
  input logic                 err_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // a burst never continues out of IDLE or BUSY
  seq_in_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (htrans_i == HTRANS_IDLE || htrans_i == HTRANS_BUSY) |=> (htrans_i != HTRANS_SEQ))
    else $error("SEQ transfer without a NONSEQ or SEQ before it");

  // wait state holds the address phase, error response may drop it
  ctrl_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!hready_i && hresp_i == HRESP_OKAY) |=>
      ($stable(haddr_i) && $stable(htrans_i) && $stable(hwrite_i) &&
       $stable(hsize_i) && $stable(hburst_i)))
    else $error("address or control changed during a wait state");

  err_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_i |=> !err_i)  // single cycle
    else $error("err_o high for more than one cycle");

  ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ack_i && err_i))
    else $error("ack_o and err_o high in the same cycle");

endmodule

//--- verif/biu_tb.sv
//////////////////////////////////////////////////////////////////////
// directed testbench for the bus interface unit
// shadow memory model, compare tasks, burst driver
//////////////////////////////////////////////////////////////////////

`include "biu_config.svh"

module biu_tb
  import biu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          PLEN          = `BIU_PLEN;
  localparam int          XLEN          = `BIU_XLEN;
  localparam int          BURST_TIMEOUT = 200;  // cycles per burst
  localparam int          RESET_TIMEOUT = 50;
  localparam logic [31:0] SEED          = 32'h78532bfa;

  logic            HCLK;
  logic            HRESETn;
  logic            stb, stb_ack, d_ack, we, ack, err;
  logic [PLEN-1:0] adr, adr_q;
  logic [XLEN-1:0] wdata, rdata;
  biu_size_e       size;
  biu_burst_e      btype;

  logic [XLEN-1:0] shadow [0:`BIU_MEM_WORDS-1];  // expected sram contents
  logic [XLEN-1:0] wbuf   [0:15];                // write data of the current burst

  tb_clk_gen i_clk_gen (.hclk_o(HCLK), .hresetn_o(HRESETn));

  biu_top i_dut (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .stb_i    (stb),
    .stb_ack_o(stb_ack),
    .d_ack_o  (d_ack),
    .adr_i    (adr),
    .adr_o    (adr_q),
    .size_i   (size),
    .type_i   (btype),
    .we_i     (we),
    .d_i      (wdata),
    .q_o      (rdata),
    .ack_o    (ack),
    .err_o    (err)
  );

  bind biu_ahb_master biu_assert i_assert (
    .clk_i   (HCLK),
    .rst_ni  (HRESETn),
    .haddr_i (haddr_o),
    .htrans_i(htrans_o),
    .hwrite_i(hwrite_o),
    .hsize_i (hsize_o),
    .hburst_i(hburst_o),
    .hready_i(hready_i),
    .hresp_i (hresp_i),
    .ack_i   (ack_o),
    .err_i   (err_o)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic int beat_count(input biu_burst_e t);
    case (t)
      BURST_WRAP4, BURST_INCR4:   return 4;
      BURST_WRAP8, BURST_INCR8:   return 8;
      BURST_WRAP16, BURST_INCR16: return 16;
      default:                    return 1;
    endcase
  endfunction

  // next word of the burst, wrapping inside beats*4 bytes
  function automatic logic [PLEN-1:0] step_addr(input logic [PLEN-1:0] a, input biu_burst_e t);
    logic [PLEN-1:0] lin;
    logic [PLEN-1:0] wrap_mask;  // offset bits inside the wrap block
    lin = {a[PLEN-1:2], 2'b00} + 32'd4;
    case (t)
      BURST_WRAP4:  wrap_mask = 32'h0000_000f;
      BURST_WRAP8:  wrap_mask = 32'h0000_001f;
      BURST_WRAP16: wrap_mask = 32'h0000_003f;
      default:      wrap_mask = '1;  // incrementing, block is the whole map
    endcase
    return (a & ~wrap_mask) | (lin & wrap_mask);
  endfunction

  function automatic int word_index(input logic [PLEN-1:0] a);
    return int'((a >> 2) % `BIU_MEM_WORDS);  // upper bits alias
  endfunction

  // write lanes from size and low address bits
  function automatic logic [XLEN-1:0] merge_lanes(input logic [XLEN-1:0] old_w,
                                                  input logic [XLEN-1:0] new_w,
                                                  input logic [PLEN-1:0] a,
                                                  input biu_size_e s);
    logic [XLEN-1:0] mask;
    case (s)
      SIZE_BYTE:  mask = 32'h0000_00ff << (8 * a[1:0]);
      SIZE_HWORD: mask = 32'h0000_ffff << (16 * a[1]);
      default:    mask = '1;
    endcase
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] got, exp);
    if (got !== exp) stop_on_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input logic [PLEN-1:0] got, exp);
    if (got !== exp) stop_on_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) stop_on_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, exp);
    if (got != exp) stop_on_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge HCLK);  // outputs settled mid cycle
      check_flag("stb_ack_o", stb_ack, 1'b0);
      check_flag("d_ack_o", d_ack, 1'b0);
      check_flag("ack_o", ack, 1'b0);
      check_flag("err_o", err, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // burst driver
  //////////////////////////////////////////////////////////////////////

  task automatic run_burst(input logic [PLEN-1:0] base, input biu_burst_e t,
                           input biu_size_e s, input logic write);
    logic [PLEN-1:0] exp_addr [0:15];
    int              dack_cyc [0:15];  // cycle of each beat's d_ack_o
    int              beats, exp_ok, cyc, idx;
    int              n_stb_ack, n_dack, n_ack, n_err;
    logic            s_stb_ack, s_dack, done;
    beats       = beat_count(t);
    exp_ok      = beats;  // beats that complete OKAY
    exp_addr[0] = base;
    for (int k = 0; k < beats; k++) begin
      if (k > 0) exp_addr[k] = step_addr(exp_addr[k-1], t);
      if (exp_addr[k] >= `BIU_ERR_BASE && exp_ok == beats) exp_ok = k;  // first failing beat
      wbuf[k] = $urandom();
    end
    {n_stb_ack, n_dack, n_ack, n_err, cyc} = '0;
    done = 1'b0;
    @(posedge HCLK);
    stb   <= 1'b1;
    adr   <= base;
    size  <= s;
    btype <= t;
    we    <= write;
    wdata <= wbuf[0];
    while (!done) begin
      @(negedge HCLK);
      cyc++;
      if (cyc > BURST_TIMEOUT) stop_on_error("burst did not finish within the timeout");
      s_stb_ack = stb_ack;
      s_dack    = d_ack;
      if (s_stb_ack) n_stb_ack++;
      if (s_dack) begin
        if (n_stb_ack == 0) stop_on_error("d_ack_o came before stb_ack_o");
        if (n_dack >= beats) stop_on_error("more d_ack_o pulses than beats");
        dack_cyc[n_dack] = cyc;
        n_dack++;
      end
      if (ack) begin
        if (n_ack >= exp_ok) stop_on_error("ack_o for a beat that must not complete");
        idx = word_index(exp_addr[n_ack]);
        check_addr("adr_o", adr_q, exp_addr[n_ack]);
        check_count("ack_o latency", cyc - dack_cyc[n_ack], 1 + `BIU_WAIT_STATES);
        if (write) shadow[idx] = merge_lanes(shadow[idx], wbuf[n_ack], exp_addr[n_ack], s);
        else       check_data("q_o", rdata, shadow[idx]);
        n_ack++;
      end
      if (err) n_err++;
      done = (exp_ok < beats) ? (n_err > 0) : (n_ack == beats);
      @(posedge HCLK);
      if (s_stb_ack) stb <= 1'b0;  // request taken
      if (s_dack && n_dack < beats) wdata <= wbuf[n_dack];  // next beat's data
    end
    check_count("stb_ack_o pulses", n_stb_ack, 1);
    check_count("d_ack_o pulses", n_dack, (exp_ok < beats) ? exp_ok + 1 : beats);
    check_count("ack_o pulses", n_ack, exp_ok);
    check_count("err_o pulses", n_err, (exp_ok < beats) ? 1 : 0);
    expect_quiet(3);  // nothing trails the burst
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_idle_check();
    int n;
    n = 0;
    while (HRESETn !== 1'b1) begin
      @(posedge HCLK);
      n++;
      if (n > RESET_TIMEOUT) stop_on_error("reset was never released");
    end
    expect_quiet(4);
  endtask

  task automatic single_word_rw();
    run_burst(32'h0000_0100, BURST_SINGLE, SIZE_WORD, 1'b1);
    run_burst(32'h0000_0100, BURST_SINGLE, SIZE_WORD, 1'b0);
  endtask

  task automatic incr_burst_rw();
    run_burst(32'h0000_0200, BURST_INCR4, SIZE_WORD, 1'b1);
    run_burst(32'h0000_0240, BURST_INCR8, SIZE_WORD, 1'b1);
    run_burst(32'h0000_0200, BURST_INCR4, SIZE_WORD, 1'b0);
    run_burst(32'h0000_0240, BURST_INCR8, SIZE_WORD, 1'b0);
  endtask

  task automatic wrap_burst_read();
    run_burst(32'h0000_0000, BURST_INCR16, SIZE_WORD, 1'b1);  // fill 64 byte block
    run_burst(32'h0000_0008, BURST_WRAP4, SIZE_WORD, 1'b0);
    run_burst(32'h0000_0014, BURST_WRAP8, SIZE_WORD, 1'b0);
    run_burst(32'h0000_0028, BURST_WRAP16, SIZE_WORD, 1'b0);
  endtask

  task automatic byte_lane_merge();
    run_burst(32'h0000_0300, BURST_SINGLE, SIZE_WORD, 1'b1);
    run_burst(32'h0000_0301, BURST_SINGLE, SIZE_BYTE, 1'b1);   // lane 1
    run_burst(32'h0000_0302, BURST_SINGLE, SIZE_HWORD, 1'b1);  // lanes 2, 3
    run_burst(32'h0000_0300, BURST_SINGLE, SIZE_WORD, 1'b0);
    run_burst(32'h0000_0304, BURST_SINGLE, SIZE_WORD, 1'b1);
    run_burst(32'h0000_0307, BURST_SINGLE, SIZE_BYTE, 1'b1);   // top lane
    run_burst(32'h0000_0304, BURST_SINGLE, SIZE_HWORD, 1'b1);  // low half
    run_burst(32'h0000_0304, BURST_SINGLE, SIZE_WORD, 1'b0);
  endtask

  // third beat hits the error window, its alias at word 0 stays put
  task automatic error_abort();
    run_burst(32'h0000_0ff8, BURST_INCR4, SIZE_WORD, 1'b1);
    run_burst(32'h0000_0000, BURST_INCR4, SIZE_WORD, 1'b0);
    run_burst(32'h0000_0ff8, BURST_SINGLE, SIZE_WORD, 1'b0);
    run_burst(32'h0000_0ffc, BURST_SINGLE, SIZE_WORD, 1'b0);
  endtask

  initial begin
    stb   = 1'b0;
    adr   = '0;
    size  = SIZE_WORD;
    btype = BURST_SINGLE;
    we    = 1'b0;
    wdata = '0;
    void'($urandom(SEED));  // one seed for all data
    reset_idle_check();
    single_word_rw();
    incr_burst_rw();
    wrap_burst_read();
    byte_lane_merge();
    error_abort();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- verif/tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset source
//////////////////////////////////////////////////////////////////////

module tb_clk_gen (
  output logic hclk_o,
  output logic hresetn_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 20;  // 40 ns bus clock
  localparam int RESET_CYCLES = 8;

  initial begin
    hclk_o = 1'b0;
    forever #(HALF_PERIOD) hclk_o = ~hclk_o;
  end

  initial begin
    hresetn_o = 1'b0;  // held low from time zero
    repeat (RESET_CYCLES) @(posedge hclk_o);
    hresetn_o <= 1'b1;  // released on a rising edge
  end

endmodule

//--- verilog/ahb_sram.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite sram slave
// wait states, byte lane writes, two-cycle error window
//////////////////////////////////////////////////////////////////////

`include "biu_config.svh"

module ahb_sram
  import biu_pkg::*;
(
  input  logic                 HCLK,
  input  logic                 HRESETn,

  input  logic                 hsel_i,
  input  logic [`BIU_PLEN-1:0] haddr_i,
  input  htrans_e              htrans_i,
  input  logic                 hwrite_i,
  input  hsize_e               hsize_i,
  input  logic [`BIU_XLEN-1:0] hwdata_i,
  output logic [`BIU_XLEN-1:0] hrdata_o,
  output logic                 hready_o,
  output hresp_e               hresp_o
);

  localparam int IDX_W  = $clog2(`BIU_MEM_WORDS);
  localparam int NB     = `BIU_XLEN / 8;                  // byte lanes
  localparam int WCNT_W = $clog2(`BIU_WAIT_STATES + 2);  // at least one bit

  typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_ERR1, ST_ERR2} sram_state_e;

  sram_state_e         state;
  logic [WCNT_W-1:0]   wcnt;       // wait cycles left in this data phase
  logic                accept;     // address phase taken
  logic                mem_we;

  // address phase copy, only meaningful in ST_DATA
  logic [IDX_W-1:0]    dph_idx;
  logic [1:0]          dph_ofs;
  hsize_e              dph_size;
  logic                dph_write;
  logic [NB-1:0]       byte_en;

  logic [`BIU_XLEN-1:0] mem [0:`BIU_MEM_WORDS-1];

  //////////////////////////////////////////////////////////////////////
  // response FSM
  //////////////////////////////////////////////////////////////////////

  assign accept = hready_o & hsel_i & (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= ST_IDLE;
      wcnt  <= '0;
    end else if (hready_o) begin
      if (accept && haddr_i >= `BIU_ERR_BASE) begin
        state <= ST_ERR1;  // outside the window, no wait states
      end else if (accept) begin
        state <= ST_DATA;
        wcnt  <= WCNT_W'(`BIU_WAIT_STATES);
      end else begin
        state <= ST_IDLE;
      end
    end else if (state == ST_ERR1) begin
      state <= ST_ERR2;
    end else begin
      wcnt <= wcnt - 1'b1;  // counting down wait states
    end
  end

  always_comb begin
    case (state)
      ST_DATA: hready_o = (wcnt == '0);
      ST_ERR1: hready_o = 1'b0;
      default: hready_o = 1'b1;  // idle and second error cycle
    endcase
  end

  assign hresp_o = (state == ST_ERR1 || state == ST_ERR2) ? HRESP_ERROR : HRESP_OKAY;

  //////////////////////////////////////////////////////////////////////
  // memory
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (accept) begin
      dph_idx   <= haddr_i[IDX_W+1:2];  // word index, upper bits alias
      dph_ofs   <= haddr_i[1:0];
      dph_size  <= hsize_i;
      dph_write <= hwrite_i;
    end
  end

  // lanes from size and low address bits
  always_comb begin
    case (dph_size)
      HSIZE_BYTE:  byte_en = NB'(1) << dph_ofs;
      HSIZE_HWORD: byte_en = NB'(2'b11) << {dph_ofs[1], 1'b0};
      default:     byte_en = '1;
    endcase
  end

  assign mem_we = (state == ST_DATA) && (wcnt == '0) && dph_write;  // last data cycle

  always_ff @(posedge HCLK) begin
    if (mem_we) begin
      for (int b = 0; b < NB; b++) begin
        if (byte_en[b]) begin
          mem[dph_idx][8*b +: 8] <= hwdata_i[8*b +: 8];
        end
      end
    end
  end

  assign hrdata_o = mem[dph_idx];  // whole word, master picks lanes

endmodule

//--- verilog/biu_ahb_master.sv
//////////////////////////////////////////////////////////////////////
// core strobe bus to AHB-Lite master
// burst counter, beat address stepping, data phase pipeline
//////////////////////////////////////////////////////////////////////

`include "biu_config.svh"

module biu_ahb_master
  import biu_pkg::*;
(
  input  logic                 HCLK,
  input  logic                 HRESETn,

  // core strobe bus
  input  logic                 stb_i,      // request, held until stb_ack_o
  output logic                 stb_ack_o,  // request taken
  output logic                 d_ack_o,    // beat address accepted, d_i consumed
  input  logic [`BIU_PLEN-1:0] adr_i,
  output logic [`BIU_PLEN-1:0] adr_o,      // address of the completing beat
  input  biu_size_e            size_i,
  input  biu_burst_e           type_i,
  input  logic                 we_i,
  input  logic [`BIU_XLEN-1:0] d_i,
  output logic [`BIU_XLEN-1:0] q_o,
  output logic                 ack_o,      // beat done
  output logic                 err_o,      // beat failed, burst dropped

  // AHB-Lite master side
  output logic [`BIU_PLEN-1:0] haddr_o,
  output htrans_e              htrans_o,
  output logic                 hwrite_o,
  output hsize_e               hsize_o,
  output hburst_e              hburst_o,
  output logic                 hsel_o,
  output logic [`BIU_XLEN-1:0] hwdata_o,
  input  logic [`BIU_XLEN-1:0] hrdata_i,
  input  logic                 hready_i,
  input  hresp_e               hresp_i
);

  //////////////////////////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////////////////////////

  logic [3:0] burst_cnt;   // beats still to issue after the current one
  logic       data_ena;    // a beat sits in the address phase
  logic       data_ena_d;  // a beat sits in the data phase
  logic       burst_idle;

  assign burst_idle = (burst_cnt == 4'd0);

  //////////////////////////////////////////////////////////////////////
  // address phase
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      burst_cnt <= 4'd0;
      data_ena  <= 1'b0;
      err_o     <= 1'b0;
      hsel_o    <= 1'b0;
      htrans_o  <= HTRANS_IDLE;
      haddr_o   <= '0;
      hwrite_o  <= 1'b0;
      hsize_o   <= HSIZE_WORD;
      hburst_o  <= HBURST_SINGLE;
    end else begin
      err_o <= 1'b0;  // pulse only

      if (hready_i) begin
        if (burst_idle) begin
          if (stb_i && !err_o) begin  // new burst, first beat
            data_ena  <= 1'b1;
            burst_cnt <= burst_beats(type_i);
            hsel_o    <= 1'b1;
            htrans_o  <= HTRANS_NONSEQ;
            haddr_o   <= adr_i;
            hwrite_o  <= we_i;
            hsize_o   <= size_to_hsize(size_i);
            hburst_o  <= burst_to_hburst(type_i);
          end else begin
            data_ena <= 1'b0;
            hsel_o   <= 1'b0;
            htrans_o <= HTRANS_IDLE;
          end
        end else begin  // remaining beats
          data_ena  <= 1'b1;
          burst_cnt <= burst_cnt - 4'd1;
          htrans_o  <= HTRANS_SEQ;
          haddr_o   <= next_beat_addr(haddr_o, hburst_o);
        end
      end else if (hresp_i == HRESP_ERROR) begin
        // first error cycle, drop the rest of the burst
        burst_cnt <= 4'd0;
        data_ena  <= 1'b0;
        hsel_o    <= 1'b0;
        htrans_o  <= HTRANS_IDLE;  // idle in the second error cycle
        err_o     <= 1'b1;
      end
      // plain wait state: everything holds
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data phase
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      data_ena_d <= 1'b0;
    end else if (hready_i) begin
      data_ena_d <= data_ena;  // beat moves into data phase
    end
  end

  // write data and beat address follow the accepted address phase
  always_ff @(posedge HCLK) begin
    if (d_ack_o) begin
      hwdata_o <= d_i;
      adr_o    <= haddr_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // core side handshakes
  //////////////////////////////////////////////////////////////////////

  assign stb_ack_o = hready_i & burst_idle & stb_i & ~err_o;  // same as burst start
  assign d_ack_o   = hready_i & data_ena;
  assign ack_o     = hready_i & data_ena_d & (hresp_i == HRESP_OKAY);  // none on error
  assign q_o       = hrdata_i;

endmodule

//--- verilog/biu_config.svh
//////////////////////////////////////////////////////////////////////
// bus interface unit build settings
// data and address widths, sram depth, wait states, error window
//////////////////////////////////////////////////////////////////////

`ifndef BIU_CONFIG_SVH
`define BIU_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

`define BIU_XLEN 32  // data width, fixed
`define BIU_PLEN 32  // physical address width

//////////////////////////////////////////////////////////////////////
// sram slave
//////////////////////////////////////////////////////////////////////

// number of 32-bit words behind the slave
`define BIU_MEM_WORDS 256

`define BIU_WAIT_STATES 1  // extra hready low cycles per data phase

// anything at or above this byte address answers ERROR
`define BIU_ERR_BASE 32'h0000_1000

`endif

//--- verilog/biu_pkg.sv
//////////////////////////////////////////////////////////////////////
// core bus and AHB-Lite encodings
// size, burst and address conversion functions
//////////////////////////////////////////////////////////////////////

`include "biu_config.svh"

package biu_pkg;

  // core side codes
  typedef enum logic [2:0] {
    BURST_SINGLE = 3'd0,
    BURST_INCR   = 3'd1,
    BURST_WRAP4  = 3'd2,
    BURST_INCR4  = 3'd3,
    BURST_WRAP8  = 3'd4,
    BURST_INCR8  = 3'd5,
    BURST_WRAP16 = 3'd6,
    BURST_INCR16 = 3'd7
  } biu_burst_e;

  typedef enum logic [2:0] {SIZE_BYTE = 3'd0, SIZE_HWORD = 3'd1, SIZE_WORD = 3'd2} biu_size_e;

  // AHB-Lite side
  typedef enum logic [1:0] {HTRANS_IDLE, HTRANS_BUSY, HTRANS_NONSEQ, HTRANS_SEQ} htrans_e;
  typedef enum logic [2:0] {
    HBURST_SINGLE, HBURST_INCR, HBURST_WRAP4, HBURST_INCR4,
    HBURST_WRAP8, HBURST_INCR8, HBURST_WRAP16, HBURST_INCR16
  } hburst_e;
  typedef enum logic [2:0] {HSIZE_BYTE = 3'd0, HSIZE_HWORD = 3'd1, HSIZE_WORD = 3'd2} hsize_e;
  typedef enum logic {HRESP_OKAY, HRESP_ERROR} hresp_e;

  // beats in the burst, minus one
  function automatic logic [3:0] burst_beats(biu_burst_e t);
    case (t)
      BURST_WRAP4, BURST_INCR4:   return 4'd3;
      BURST_WRAP8, BURST_INCR8:   return 4'd7;
      BURST_WRAP16, BURST_INCR16: return 4'd15;
      default:                    return 4'd0;  // single, open incr
    endcase
  endfunction

  function automatic hburst_e burst_to_hburst(biu_burst_e t);
    case (t)
      BURST_INCR:   return HBURST_INCR;
      BURST_WRAP4:  return HBURST_WRAP4;
      BURST_INCR4:  return HBURST_INCR4;
      BURST_WRAP8:  return HBURST_WRAP8;
      BURST_INCR8:  return HBURST_INCR8;
      BURST_WRAP16: return HBURST_WRAP16;
      BURST_INCR16: return HBURST_INCR16;
      default:      return HBURST_SINGLE;
    endcase
  endfunction

  function automatic hsize_e size_to_hsize(biu_size_e s);
    case (s)
      SIZE_BYTE:  return HSIZE_BYTE;
      SIZE_HWORD: return HSIZE_HWORD;
      default:    return HSIZE_WORD;  // no dword on a 32-bit bus
    endcase
  endfunction

  // step to the next word, wrap keeps the upper bits of the block
  function automatic logic [`BIU_PLEN-1:0] next_beat_addr(logic [`BIU_PLEN-1:0] addr,
                                                          hburst_e hb);
    logic [`BIU_PLEN-1:0] lin;
    lin = {addr[`BIU_PLEN-1:2] + 1'b1, 2'b00};  // linear, word aligned
    case (hb)
      HBURST_WRAP4:  return {addr[`BIU_PLEN-1:4], lin[3:0]};  // 16 byte block
      HBURST_WRAP8:  return {addr[`BIU_PLEN-1:5], lin[4:0]};  // 32 byte block
      HBURST_WRAP16: return {addr[`BIU_PLEN-1:6], lin[5:0]};  // 64 byte block
      default:       return lin;
    endcase
  endfunction

endpackage

//--- verilog/biu_top.sv
//////////////////////////////////////////////////////////////////////
// bus interface unit subsystem
// AHB-Lite master and sram slave on one internal bus
//////////////////////////////////////////////////////////////////////

`include "biu_config.svh"

module biu_top
  import biu_pkg::*;
(
  input  logic                 HCLK,
  input  logic                 HRESETn,

  // core strobe bus
  input  logic                 stb_i,
  output logic                 stb_ack_o,
  output logic                 d_ack_o,
  input  logic [`BIU_PLEN-1:0] adr_i,
  output logic [`BIU_PLEN-1:0] adr_o,
  input  biu_size_e            size_i,
  input  biu_burst_e           type_i,
  input  logic                 we_i,
  input  logic [`BIU_XLEN-1:0] d_i,
  output logic [`BIU_XLEN-1:0] q_o,
  output logic                 ack_o,
  output logic                 err_o
);

  //////////////////////////////////////////////////////////////////////
  // internal AHB-Lite bus
  //////////////////////////////////////////////////////////////////////

  logic [`BIU_PLEN-1:0] haddr;
  htrans_e              htrans;
  logic                 hwrite;
  hsize_e               hsize;
  hburst_e              hburst;   // burst type, informational for the sram
  logic                 hsel;
  logic [`BIU_XLEN-1:0] hwdata;
  logic [`BIU_XLEN-1:0] hrdata;
  logic                 hready;   // single slave, readyout feeds back directly
  hresp_e               hresp;

  biu_ahb_master i_master (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .stb_i    (stb_i),
    .stb_ack_o(stb_ack_o),
    .d_ack_o  (d_ack_o),
    .adr_i    (adr_i),
    .adr_o    (adr_o),
    .size_i   (size_i),
    .type_i   (type_i),
    .we_i     (we_i),
    .d_i      (d_i),
    .q_o      (q_o),
    .ack_o    (ack_o),
    .err_o    (err_o),
    .haddr_o  (haddr),
    .htrans_o (htrans),
    .hwrite_o (hwrite),
    .hsize_o  (hsize),
    .hburst_o (hburst),
    .hsel_o   (hsel),
    .hwdata_o (hwdata),
    .hrdata_i (hrdata),
    .hready_i (hready),
    .hresp_i  (hresp)
  );

  ahb_sram i_sram (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .hsel_i  (hsel),
    .haddr_i (haddr),
    .htrans_i(htrans),
    .hwrite_i(hwrite),
    .hsize_i (hsize),
    .hwdata_i(hwdata),
    .hrdata_o(hrdata),
    .hready_o(hready),
    .hresp_o (hresp)
  );

endmodule
